/* sim.f */
design/intra4_pkg.sv
design/intra4_ctrl_pkg.sv
design/intra4_if.sv
design/sub_block_counter.sv
design/pick_intra4_ctrl.sv
design/intra4_predictor.sv
design/mode_scorer.sv
design/edge_buffer.sv
design/pick_best_intra4.sv
tests/pick_best_intra4_props.sv
tests/pick_best_intra4_tb.sv

/* Makefile */
# Verilator build and run of the intra 4x4 mode decision testbench

VERILATOR ?= verilator
TOP       ?= pick_best_intra4_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/pick_best_intra4_tb.sv */
// Testbench for the intra 4x4 luma mode decision engine
// Runs fixed and random macroblocks, checks them against a reference model
module pick_best_intra4_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAMBDA_W   = 16;
    localparam int NUM_TESTS  = 26;
    localparam int CLK_PERIOD = 4;
    // Load and done, then four cycles per sub-block
    localparam int DONE_LATENCY = 2 + 4 * 16;

    logic                clk;
    logic                rst_n;
    logic                start_i;
    logic [LAMBDA_W-1:0] lambda_i;
    logic [2047:0]       ysrc_i;
    logic [127:0]        top_i;
    logic [127:0]        left_i;
    logic [7:0]          top_left_i;
    logic [2047:0]       yout_o;
    logic [31:0]         modes_o;
    logic [31:0]         score_o;
    logic                done_o;

    // Next block and its expected result
    logic [2047:0] src_blk;
    logic [127:0]  top_row;
    logic [127:0]  left_col;
    logic [7:0]    corner_px;
    int unsigned   lam;
    logic [2047:0] exp_yout;
    logic [31:0]   exp_modes;
    logic [31:0]   exp_score;
    string         test_name;
    time           start_time = 0;
    int            blocks_started = 0;
    int            blocks_checked = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            error_count = 0;

    pick_best_intra4 #(.LAMBDA_W(LAMBDA_W)) pick_best_intra4_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .lambda_i  (lambda_i),
        .ysrc_i    (ysrc_i),
        .top_i     (top_i),
        .left_i    (left_i),
        .top_left_i(top_left_i),
        .yout_o    (yout_o),
        .modes_o   (modes_o),
        .score_o   (score_o),
        .done_o    (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int unsigned fixed_cost(input int m);
        case (m)
            0:       return 40;
            1:       return 1151;
            2:       return 1723;
            default: return 1874;
        endcase
    endfunction

    function automatic void ref_model(
        input  logic [2047:0] s,
        input  logic [127:0]  t_in,
        input  logic [127:0]  l_in,
        input  logic [7:0]    tl,
        input  int unsigned   lmb,
        output logic [2047:0] yout,
        output logic [31:0]   modes,
        output logic [31:0]   score
    );
        int     rec [16][16];
        int     t [4];
        int     l [4];
        int     pred [4][16];
        int     c;
        int     r0;
        int     c0;
        int     dc;
        int     tm;
        int     d;
        int     best;
        longint sse;
        longint cost;
        longint best_cost;
        score = 211 * lmb;
        modes = '0;
        yout  = '0;
        for (int sb = 0; sb < 16; sb++) begin
            r0 = (sb / 4) * 4;
            c0 = (sb % 4) * 4;
            // Neighbours come from the reconstruction inside the macroblock
            for (int i = 0; i < 4; i++) begin
                t[i] = (r0 == 0) ? int'(t_in[(c0 + i)*8 +: 8]) : rec[r0-1][c0+i];
                l[i] = (c0 == 0) ? int'(l_in[(r0 + i)*8 +: 8]) : rec[r0+i][c0-1];
            end
            if (r0 == 0) begin
                c = (c0 == 0) ? int'(tl) : int'(t_in[(c0 - 1)*8 +: 8]);
            end else begin
                c = (c0 == 0) ? int'(l_in[(r0 - 1)*8 +: 8]) : rec[r0-1][c0-1];
            end
            dc = (t[0] + t[1] + t[2] + t[3] + l[0] + l[1] + l[2] + l[3] + 4) >> 3;
            for (int p = 0; p < 16; p++) begin
                tm = l[p/4] + t[p%4] - c;
                pred[0][p] = dc;
                pred[1][p] = (tm < 0) ? 0 : ((tm > 255) ? 255 : tm);
                pred[2][p] = t[p%4];
                pred[3][p] = l[p/4];
            end
            // Ties keep the lower mode
            best      = 0;
            best_cost = 0;
            for (int m = 0; m < 4; m++) begin
                sse = 0;
                for (int p = 0; p < 16; p++) begin
                    d   = int'(s[((r0 + p/4)*16 + c0 + p%4)*8 +: 8]) - pred[m][p];
                    sse = sse + longint'(d * d);
                end
                cost = sse + longint'(lmb) * longint'(fixed_cost(m));
                if (m == 0 || cost < best_cost) begin
                    best      = m;
                    best_cost = cost;
                end
            end
            modes[sb*2 +: 2] = 2'(best);
            score = score + 32'(best_cost);
            for (int p = 0; p < 16; p++) begin
                rec[r0 + p/4][c0 + p%4] = pred[best][p];
                yout[((r0 + p/4)*16 + c0 + p%4)*8 +: 8] = 8'(pred[best][p]);
            end
        end
    endfunction

    // ----------------------------------------
    // Checks and stimulus helpers
    // ----------------------------------------
    task automatic check_value(input string name, input logic [2047:0] got,
                               input logic [2047:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error: time %0t signal %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, error_count - errors_before);
        end
    endtask

    function automatic void fill_random_block(input int unsigned max_lambda);
        for (int i = 0; i < 64; i++) begin
            src_blk[i*32 +: 32] = $urandom;
        end
        top_row   = {$urandom, $urandom, $urandom, $urandom};
        left_col  = {$urandom, $urandom, $urandom, $urandom};
        corner_px = 8'($urandom);
        lam       = $urandom_range(0, max_lambda);
    endfunction

    task automatic run_block(input string name, input bit extra_start);
        ref_model(src_blk, top_row, left_col, corner_px, lam, exp_yout, exp_modes, exp_score);
        test_name = name;
        blocks_started++;
        @(posedge clk);
        ysrc_i     <= src_blk;
        top_i      <= top_row;
        left_i     <= left_col;
        top_left_i <= corner_px;
        lambda_i   <= LAMBDA_W'(lam);
        start_i    <= 1'b1;
        @(posedge clk);
        start_time = $time;
        start_i <= 1'b0;
        if (extra_start) begin
            // Second pulse lands while the block is busy
            repeat (10) @(posedge clk);
            start_i <= 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
        end
        wait (blocks_checked == blocks_started);
    endtask

    task automatic expect_idle(input string name, input int cycles);
        int errors_before;
        test_name     = name;
        errors_before = error_count;
        repeat (cycles) begin
            @(negedge clk);
            check_value("done_o", 2048'(done_o), 2048'(1'b0));
        end
        report_test(errors_before);
    endtask

    // Compare each finished block with its expected result
    initial begin
        int errors_before;
        int latency;
        forever begin
            @(negedge clk);
            if (done_o) begin
                errors_before = error_count;
                // Whole cycles from the edge that took start_i to the edge that raised done_o
                latency = int'(($time - start_time) / CLK_PERIOD);
                check_value("done_o latency", 2048'(latency), 2048'(DONE_LATENCY));
                check_value("yout_o", yout_o, exp_yout);
                check_value("modes_o", 2048'(modes_o), 2048'(exp_modes));
                check_value("score_o", 2048'(score_o), 2048'(exp_score));
                report_test(errors_before);
                blocks_checked++;
            end
        end
    end

    initial begin
        void'($urandom(80671));
        rst_n      = 1'b0;
        start_i    = 1'b0;
        lambda_i   = '0;
        ysrc_i     = '0;
        top_i      = '0;
        left_i     = '0;
        top_left_i = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        expect_idle("reset_idle", 5);

        src_blk   = {256{8'd100}};
        top_row   = {16{8'd100}};
        left_col  = {16{8'd100}};
        corner_px = 8'd100;
        lam       = 5;
        run_block("flat", 1'b0);

        // Every source column repeats the top edge
        fill_random_block(0);
        for (int i = 0; i < 256; i++) begin
            src_blk[i*8 +: 8] = top_row[(i % 16)*8 +: 8];
        end
        lam = 0;
        run_block("vertical", 1'b0);

        // Rows follow the left edge with a one-step ripple
        fill_random_block(0);
        for (int i = 0; i < 16; i++) begin
            left_col[i*8 +: 8] = 8'($urandom_range(0, 250));
        end
        for (int i = 0; i < 256; i++) begin
            src_blk[i*8 +: 8] = left_col[(i / 16)*8 +: 8] + 8'(i % 2);
        end
        lam = 3;
        run_block("horizontal", 1'b0);

        for (int n = 0; n < 20; n++) begin
            fill_random_block(40);
            run_block($sformatf("random_%0d", n), 1'b0);
        end

        fill_random_block(20);
        run_block("start_ignored", 1'b1);
        expect_idle("no_restart", 70);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_TESTS * 100) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", NUM_TESTS * 100);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* tests/pick_best_intra4_props.sv */
// Control checks for the intra 4x4 decision controller
// Bound to the controller, watches done, store and issue timing
module pick_best_intra4_props (
    input logic                         clk,
    input logic                         rst_n,
    input intra4_ctrl_pkg::ctrl_state_e state,
    input logic                         issue_o,
    input logic                         store_o,
    input logic                         done_o,
    input logic                         dec_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |=> !done_o)
        else $error("done_o stayed high for more than one cycle");

    // Decision is written back in the cycle after it arrives
    store_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |=> store_o)
        else $error("store_o did not follow a valid decision");

    // Scorer answers while the controller sits in the second score state
    decision_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue_o |-> ##2 (dec_valid && state == intra4_ctrl_pkg::ST_SCORE2))
        else $error("decision did not arrive two cycles after issue_o");

endmodule

bind pick_intra4_ctrl pick_best_intra4_props ctrl_props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .state    (state),
    .issue_o  (issue_o),
    .store_o  (store_o),
    .done_o   (done_o),
    .dec_valid(dec.valid)
);

/* design/pick_best_intra4.sv */
// Intra 4x4 luma mode decision for one 16x16 macroblock
// Picks the cheapest of DC, TM, VE and HE for each sub-block in raster
// order and returns the reconstruction, the modes and the total score
module pick_best_intra4 #(
    parameter int LAMBDA_W = 16
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 start_i,
    input  logic [LAMBDA_W-1:0]                                  lambda_i,
    input  logic [intra4_pkg::MB_SIZE*intra4_pkg::MB_SIZE*8-1:0] ysrc_i,
    input  logic [intra4_pkg::MB_SIZE*8-1:0]                     top_i,
    input  logic [intra4_pkg::MB_SIZE*8-1:0]                     left_i,
    input  logic [7:0]                                           top_left_i,
    output logic [intra4_pkg::MB_SIZE*intra4_pkg::MB_SIZE*8-1:0] yout_o,
    output logic [2*intra4_pkg::NUM_SB-1:0]                      modes_o,
    output logic [intra4_pkg::COST_W-1:0]                        score_o,
    output logic                                                 done_o
);

    logic                                               clear;
    logic                                               step;
    logic                                               load;
    logic                                               issue;
    logic                                               store;
    logic                                               last;
    logic [3:0]                                         sb_idx;
    intra4_pkg::sb_pixels_t                             src;
    logic [31:0]                                        top_nb;
    logic [31:0]                                        left_nb;
    intra4_pkg::pixel_t                                 corner;
    intra4_pkg::sb_pixels_t [intra4_pkg::NUM_MODES-1:0] preds;

    decision_if dec_if ();

    pick_intra4_ctrl #(.LAMBDA_W(LAMBDA_W)) ctrl_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .lambda_i(lambda_i),
        .last_i  (last),
        .clear_o (clear),
        .step_o  (step),
        .load_o  (load),
        .issue_o (issue),
        .store_o (store),
        .score_o (score_o),
        .done_o  (done_o),
        .dec     (dec_if.ctrl)
    );

    sub_block_counter counter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear_i (clear),
        .step_i  (step),
        .sb_idx_o(sb_idx),
        .last_o  (last)
    );

    edge_buffer edge_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_i    (load),
        .store_i   (store),
        .sb_idx_i  (sb_idx),
        .ysrc_i    (ysrc_i),
        .top_i     (top_i),
        .left_i    (left_i),
        .top_left_i(top_left_i),
        .src_o     (src),
        .top_o     (top_nb),
        .left_o    (left_nb),
        .corner_o  (corner),
        .yout_o    (yout_o),
        .modes_o   (modes_o),
        .dec       (dec_if.store)
    );

    intra4_predictor pred_i (
        .top_i   (top_nb),
        .left_i  (left_nb),
        .corner_i(corner),
        .preds_o (preds)
    );

    mode_scorer #(.LAMBDA_W(LAMBDA_W)) scorer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue_i (issue),
        .lambda_i(lambda_i),
        .src_i   (src),
        .preds_i (preds),
        .dec     (dec_if.scorer)
    );

endmodule

/* design/edge_buffer.sv */
// Intra 4x4 neighbour and output buffer
// Keeps the top line, left column and corner for the current sub-block,
// collects the chosen pixels and modes, and selects the source sub-block
module edge_buffer (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   load_i,
    input  logic                                   store_i,
    input  logic [3:0]                             sb_idx_i,
    input  logic [intra4_pkg::MB_SIZE*intra4_pkg::MB_SIZE*8-1:0] ysrc_i,
    input  logic [intra4_pkg::MB_SIZE*8-1:0]       top_i,
    input  logic [intra4_pkg::MB_SIZE*8-1:0]       left_i,
    input  intra4_pkg::pixel_t                     top_left_i,
    output intra4_pkg::sb_pixels_t                 src_o,
    output logic [31:0]                            top_o,
    output logic [31:0]                            left_o,
    output intra4_pkg::pixel_t                     corner_o,
    output logic [intra4_pkg::MB_SIZE*intra4_pkg::MB_SIZE*8-1:0] yout_o,
    output logic [2*intra4_pkg::NUM_SB-1:0]        modes_o,
    decision_if.store                              dec
);

    logic [intra4_pkg::MB_SIZE*8-1:0] top_line;
    logic [1:0]                       sb_row;
    logic [1:0]                       sb_col;
    logic [1:0]                       next_row;
    logic [31:0]                      right_col;

    assign sb_row    = sb_idx_i[3:2];
    assign sb_col    = sb_idx_i[1:0];
    assign next_row  = sb_row + 2'd1;
    assign right_col = {dec.best_pixels[15*8 +: 8], dec.best_pixels[11*8 +: 8],
                        dec.best_pixels[7*8 +: 8], dec.best_pixels[3*8 +: 8]};
    assign top_o     = top_line[sb_col*32 +: 32];

    always_comb begin
        for (int y = 0; y < 4; y++) begin
            src_o[y*32 +: 32] = ysrc_i[((sb_row*4 + y)*intra4_pkg::MB_SIZE + sb_col*4)*8 +: 32];
        end
    end

    // ----------------------------------------
    // Neighbour feedback
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            top_line <= '0;
            left_o   <= '0;
            corner_o <= '0;
            modes_o  <= '0;
        end else if (load_i) begin
            top_line <= top_i;
            left_o   <= left_i[31:0];
            corner_o <= top_left_i;
        end else if (store_i) begin
            top_line[sb_col*32 +: 32] <= dec.best_pixels[12*8 +: 32];
            modes_o[sb_idx_i*2 +: 2]  <= dec.best_mode;
            if (sb_col == 2'd3) begin
                // New row takes its left edge from outside the macroblock
                left_o   <= left_i[next_row*32 +: 32];
                corner_o <= left_i[sb_row*32 + 24 +: 8];
            end else begin
                left_o   <= right_col;
                corner_o <= top_line[sb_col*32 + 24 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_i) begin
            for (int y = 0; y < 4; y++) begin
                yout_o[((sb_row*4 + y)*intra4_pkg::MB_SIZE + sb_col*4)*8 +: 32]
                    <= dec.best_pixels[y*32 +: 32];
            end
        end
    end

endmodule

/* design/mode_scorer.sv */
// Intra 4x4 mode scorer
// Stage one sums squared errors per mode, stage two adds the
// lambda-weighted fixed cost and registers the cheapest mode
module mode_scorer #(
    parameter int LAMBDA_W = 16
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               issue_i,
    input  logic [LAMBDA_W-1:0]                                lambda_i,
    input  intra4_pkg::sb_pixels_t                             src_i,
    input  intra4_pkg::sb_pixels_t [intra4_pkg::NUM_MODES-1:0] preds_i,
    decision_if.scorer                                         dec
);

    logic [intra4_pkg::SB_SSE_W-1:0] sse_d [intra4_pkg::NUM_MODES];
    logic [intra4_pkg::SB_SSE_W-1:0] sse_q [intra4_pkg::NUM_MODES];
    logic [intra4_pkg::COST_W-1:0]   cost [intra4_pkg::NUM_MODES];
    logic [intra4_pkg::COST_W-1:0]   min_cost;
    intra4_pkg::pred_mode_e          min_mode;
    intra4_pkg::pixel_t              a;
    intra4_pkg::pixel_t              b;
    intra4_pkg::pixel_t              ad;
    logic                            valid_q;

    // ----------------------------------------
    // Stage one: SSE per mode
    // ----------------------------------------
    always_comb begin
        a  = '0;
        b  = '0;
        ad = '0;
        for (int m = 0; m < intra4_pkg::NUM_MODES; m++) begin
            sse_d[m] = '0;
            for (int p = 0; p < 16; p++) begin
                a        = src_i[p*8 +: 8];
                b        = preds_i[m][p*8 +: 8];
                ad       = (a > b) ? a - b : b - a;
                sse_d[m] = sse_d[m] + intra4_pkg::SB_SSE_W'(ad * ad);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            sse_q <= sse_d;
        end
    end

    // ----------------------------------------
    // Stage two: cost and minimum
    // ----------------------------------------
    always_comb begin
        min_cost = '0;
        min_mode = intra4_pkg::MODE_DC;
        for (int m = 0; m < intra4_pkg::NUM_MODES; m++) begin
            cost[m] = sse_q[m] + lambda_i * intra4_pkg::FIXED_COST[m];
            // Strict compare keeps the lower mode on a tie
            if (m == 0 || cost[m] < min_cost) begin
                min_cost = cost[m];
                min_mode = intra4_pkg::pred_mode_e'(2'(m));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            dec.valid <= 1'b0;
        end else begin
            valid_q   <= issue_i;
            dec.valid <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q) begin
            dec.best_mode   <= min_mode;
            dec.best_cost   <= min_cost;
            dec.best_pixels <= preds_i[min_mode];
        end
    end

endmodule

/* design/intra4_predictor.sv */
// Intra 4x4 predictors
// DC, TrueMotion, Vertical and Horizontal from the sub-block neighbours
module intra4_predictor (
    input  logic [31:0]                                             top_i,
    input  logic [31:0]                                             left_i,
    input  intra4_pkg::pixel_t                                      corner_i,
    output intra4_pkg::sb_pixels_t [intra4_pkg::NUM_MODES-1:0]      preds_o
);

    intra4_pkg::pixel_t top [4];
    intra4_pkg::pixel_t left [4];
    logic [10:0]        dc_sum;
    intra4_pkg::pixel_t dc_val;
    logic signed [10:0] tm;

    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < 4; i++) begin
            top[i]  = top_i[i*8 +: 8];
            left[i] = left_i[i*8 +: 8];
            dc_sum  = dc_sum + 11'(top[i]) + 11'(left[i]);
        end
        dc_val = dc_sum[10:3];
    end

    always_comb begin
        tm = '0;
        for (int y = 0; y < 4; y++) begin
            for (int x = 0; x < 4; x++) begin
                preds_o[intra4_pkg::MODE_DC][(y*4+x)*8 +: 8] = dc_val;
                preds_o[intra4_pkg::MODE_VE][(y*4+x)*8 +: 8] = top[x];
                preds_o[intra4_pkg::MODE_HE][(y*4+x)*8 +: 8] = left[y];

                // TrueMotion, clipped to the pixel range
                tm = $signed({3'b000, left[y]}) + $signed({3'b000, top[x]})
                     - $signed({3'b000, corner_i});
                if (tm < 0) begin
                    preds_o[intra4_pkg::MODE_TM][(y*4+x)*8 +: 8] = 8'd0;
                end else if (tm > 255) begin
                    preds_o[intra4_pkg::MODE_TM][(y*4+x)*8 +: 8] = 8'd255;
                end else begin
                    preds_o[intra4_pkg::MODE_TM][(y*4+x)*8 +: 8] = tm[7:0];
                end
            end
        end
    end

endmodule

/* design/pick_intra4_ctrl.sv */
// Intra 4x4 mode decision controller
// Sequences load, predict, score and store over the 16 sub-blocks
// and accumulates the macroblock score
module pick_intra4_ctrl #(
    parameter int LAMBDA_W = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_i,
    input  logic [LAMBDA_W-1:0]           lambda_i,
    input  logic                          last_i,
    output logic                          clear_o,
    output logic                          step_o,
    output logic                          load_o,
    output logic                          issue_o,
    output logic                          store_o,
    output logic [intra4_pkg::COST_W-1:0] score_o,
    output logic                          done_o,
    decision_if.ctrl                      dec
);

    intra4_ctrl_pkg::ctrl_state_e state;
    intra4_ctrl_pkg::ctrl_state_e state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= intra4_ctrl_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            intra4_ctrl_pkg::ST_IDLE:   if (start_i) state_nxt = intra4_ctrl_pkg::ST_LOAD;
            intra4_ctrl_pkg::ST_LOAD:   state_nxt = intra4_ctrl_pkg::ST_PRED;
            intra4_ctrl_pkg::ST_PRED:   state_nxt = intra4_ctrl_pkg::ST_SCORE1;
            intra4_ctrl_pkg::ST_SCORE1: state_nxt = intra4_ctrl_pkg::ST_SCORE2;
            intra4_ctrl_pkg::ST_SCORE2: state_nxt = intra4_ctrl_pkg::ST_STORE;
            intra4_ctrl_pkg::ST_STORE: begin
                state_nxt = last_i ? intra4_ctrl_pkg::ST_DONE : intra4_ctrl_pkg::ST_PRED;
            end
            default:                    state_nxt = intra4_ctrl_pkg::ST_IDLE;
        endcase
    end

    // Enables
    assign clear_o = (state == intra4_ctrl_pkg::ST_LOAD);
    assign load_o  = (state == intra4_ctrl_pkg::ST_LOAD);
    assign issue_o = (state == intra4_ctrl_pkg::ST_PRED);
    assign store_o = (state == intra4_ctrl_pkg::ST_STORE);
    assign step_o  = (state == intra4_ctrl_pkg::ST_STORE);

    // ----------------------------------------
    // Score accumulator and done pulse
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score_o <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= (state == intra4_ctrl_pkg::ST_DONE);
            if (state == intra4_ctrl_pkg::ST_LOAD) begin
                score_o <= intra4_pkg::MODE_HEADER_COST * lambda_i;
            end else if (dec.valid) begin
                score_o <= score_o + dec.best_cost;
            end
        end
    end

endmodule

/* design/sub_block_counter.sv */
// Sub-block counter
// Raster index of the current 4x4 sub-block and a flag on the last one
module sub_block_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear_i,
    input  logic       step_i,
    output logic [3:0] sb_idx_o,
    output logic       last_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sb_idx_o <= 4'd0;
        end else if (clear_i) begin
            sb_idx_o <= 4'd0;
        end else if (step_i) begin
            // Wraps to 0 after the last sub-block
            sb_idx_o <= sb_idx_o + 4'd1;
        end
    end

    assign last_o = (sb_idx_o == 4'(intra4_pkg::NUM_SB - 1));

endmodule

/* design/intra4_if.sv */
// Decision bus from the mode scorer
// Valid pulses for one cycle; the payload holds until the next issue
interface decision_if;

    logic                            valid;
    intra4_pkg::pred_mode_e          best_mode;
    logic [intra4_pkg::COST_W-1:0]   best_cost;
    intra4_pkg::sb_pixels_t          best_pixels;

    modport scorer (
        output valid,
        output best_mode,
        output best_cost,
        output best_pixels
    );

    modport ctrl (input valid, input best_cost);

    modport store (input best_mode, input best_pixels);

endinterface

/* design/intra4_ctrl_pkg.sv */
// Intra 4x4 sequencing definitions
// States of the macroblock controller
package intra4_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_PRED,
        ST_SCORE1,
        ST_SCORE2,
        ST_STORE,
        ST_DONE
    } ctrl_state_e;

endpackage

/* design/intra4_pkg.sv */
// Intra 4x4 luma codec definitions
// Pixel and block geometry, the kept prediction modes and their costs
package intra4_pkg;

    localparam int PIX_W     = 8;
    localparam int MB_SIZE   = 16;
    localparam int SB_SIZE   = 4;
    localparam int NUM_SB    = 16;
    localparam int NUM_MODES = 4;
    localparam int COST_W    = 32;
    localparam int SB_SSE_W  = 20;

    typedef logic [PIX_W-1:0] pixel_t;

    // Pixel (y,x) at index y*4+x, lowest index in the low bits
    typedef logic [SB_SIZE*SB_SIZE*PIX_W-1:0] sb_pixels_t;

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } pred_mode_e;

    // Entry 0 is DC
    localparam logic [NUM_MODES-1:0][COST_W-1:0] FIXED_COST = {
        32'd1874, 32'd1723, 32'd1151, 32'd40
    };

    localparam logic [COST_W-1:0] MODE_HEADER_COST = 32'd211;

endpackage
